// File: build.f
design/mult_pkg.sv
design/mult_ctrl.sv
design/short_mac.sv
design/simd_mac.sv
design/mult_unit.sv
tb/mult_props.sv
tb/tb_mult.sv

// File: design/mult_ctrl.sv
// Controller inside the multiply unit top that sequences MULH and drives ready, multicycle and result
`timescale 1ns/1ps

module mult_ctrl (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      enable_i,
  input  mult_pkg::mult_req_t       req_i,
  input  logic                      ex_ready_i,
  input  logic [mult_pkg::XLEN-1:0] short_result_i,
  input  logic [mult_pkg::XLEN-1:0] simd_result_i,
  output mult_pkg::mult_step_t      step_o,
  output logic [mult_pkg::XLEN-1:0] result_o,
  output logic                      ready_o,
  output logic                      multicycle_o
);

  typedef enum logic [2:0] {IDLE, STEP0, STEP1, STEP2, FINISH} mulh_state_e;

  mulh_state_e state_q;
  mulh_state_e state_d;
  logic        mulh_start;
  logic        use_short;

  // A MULH request leaves IDLE in its accepting cycle
  assign mulh_start = enable_i && (req_i.op == mult_pkg::MUL_H);

  ////////////////////////////////////////////////////////////
  // Step sequencer
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    step_o       = '0;
    ready_o      = 1'b0;
    multicycle_o = 1'b0;
    case (state_q)
      IDLE: begin
        // Single-cycle ops complete here while MULH drops ready at once
        ready_o = !mulh_start;
        if (mulh_start) begin
          state_d = STEP0;
        end
      end
      STEP0: begin
        // Unsigned AL*BL with only the bits above the low half kept
        multicycle_o       = 1'b1;
        step_o.active      = 1'b1;
        step_o.imm         = mult_pkg::MULH_SHIFT[mult_pkg::IMM_W-1:0];
        step_o.save_carry  = 1'b1;
        state_d            = STEP1;
      end
      STEP1: begin
        // AL*BH signed only when B is signed, the 33-bit sum kept with its carry
        multicycle_o       = 1'b1;
        step_o.active      = 1'b1;
        step_o.subword     = 2'b10;
        step_o.signed_ab   = {req_i.short_signed[1], 1'b0};
        step_o.save_carry  = 1'b1;
        state_d            = STEP2;
      end
      STEP2: begin
        // AH*BL signed only when A is signed and then realigned
        multicycle_o       = 1'b1;
        step_o.active      = 1'b1;
        step_o.subword     = 2'b01;
        step_o.signed_ab   = {1'b0, req_i.short_signed[0]};
        step_o.imm         = mult_pkg::MULH_SHIFT[mult_pkg::IMM_W-1:0];
        step_o.shift_arith = 1'b1;
        step_o.save_carry  = 1'b1;
        // Upper bits come back through the arithmetic shift
        step_o.clear_carry = 1'b1;
        state_d            = FINISH;
      end
      FINISH: begin
        // AH*BH with the request's signedness and held until accepted
        ready_o          = 1'b1;
        step_o.active    = 1'b1;
        step_o.subword   = 2'b11;
        step_o.signed_ab = req_i.short_signed;
        if (ex_ready_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Result selection
  ////////////////////////////////////////////////////////////

  // Short datapath serves the subword ops and MULH
  assign use_short = (req_i.op == mult_pkg::MUL_I)  ||
                     (req_i.op == mult_pkg::MUL_IR) ||
                     (req_i.op == mult_pkg::MUL_H);

  assign result_o = use_short ? short_result_i : simd_result_i;

endmodule

// File: design/mult_pkg.sv
// Shared widths, operator codes and bundle types of the multiply unit, used by scoped name
package mult_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Operand and result width
  localparam int XLEN       = 32;
  // Subword lane of the short MAC and of DOT16
  localparam int HALF_W     = 16;
  // Lane of DOT8
  localparam int BYTE_W     = 8;
  // Realignment between the MULH partial products
  localparam int MULH_SHIFT = 16;
  // Shift amount field
  localparam int IMM_W      = 5;
  localparam int NUM_BYTES  = XLEN / BYTE_W;
  localparam int NUM_HALVES = XLEN / HALF_W;

  ////////////////////////////////////////////////////////////
  // Operator codes and operand views
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    MUL_MAC32 = 3'b000,
    MUL_I     = 3'b010,
    MUL_IR    = 3'b011,
    MUL_H     = 3'b110,
    MUL_DOT8  = 3'b100,
    MUL_DOT16 = 3'b101
  } mult_op_e;

  // One operand word, split into byte lanes or halfword lanes
  typedef union packed {
    logic [NUM_BYTES-1:0][BYTE_W-1:0]  bytes;
    logic [NUM_HALVES-1:0][HALF_W-1:0] halves;
  } mult_word_u;

  // Request as presented by the execute stage
  typedef struct packed {
    mult_op_e         op;
    logic             short_subword;
    logic [1:0]       short_signed;   // bit 0 for A, bit 1 for B
    logic [IMM_W-1:0] imm;
    logic [1:0]       dot_signed;     // bit 1 for A, bit 0 for B
  } mult_req_t;

  // MULH step controls, override the short datapath while active
  typedef struct packed {
    logic             active;
    logic [IMM_W-1:0] imm;
    logic [1:0]       subword;        // bit 0 selects A high, bit 1 selects B high
    logic [1:0]       signed_ab;
    logic             shift_arith;
    logic             save_carry;
    logic             clear_carry;
  } mult_step_t;

endpackage

// File: design/mult_unit.sv
// Top of the multiply unit, packs the request and wires the controller to both datapaths
`timescale 1ns/1ps

module mult_unit (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      enable_i,
  input  mult_pkg::mult_op_e        operator_i,
  input  logic                      short_subword_i,
  input  logic [1:0]                short_signed_i,
  input  logic [mult_pkg::IMM_W-1:0] imm_i,
  input  logic [1:0]                dot_signed_i,
  input  logic [mult_pkg::XLEN-1:0] op_a_i,
  input  logic [mult_pkg::XLEN-1:0] op_b_i,
  input  logic [mult_pkg::XLEN-1:0] op_c_i,
  input  logic                      ex_ready_i,
  output logic [mult_pkg::XLEN-1:0] result_o,
  output logic                      ready_o,
  output logic                      multicycle_o
);

  mult_pkg::mult_req_t       req;
  mult_pkg::mult_step_t      step;
  logic [mult_pkg::XLEN-1:0] short_result;
  logic [mult_pkg::XLEN-1:0] simd_result;

  // Request fields bundled once for all three blocks
  assign req.op            = operator_i;
  assign req.short_subword = short_subword_i;
  assign req.short_signed  = short_signed_i;
  assign req.imm           = imm_i;
  assign req.dot_signed    = dot_signed_i;

  mult_ctrl u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .enable_i      (enable_i),
    .req_i         (req),
    .ex_ready_i    (ex_ready_i),
    .short_result_i(short_result),
    .simd_result_i (simd_result),
    .step_o        (step),
    .result_o      (result_o),
    .ready_o       (ready_o),
    .multicycle_o  (multicycle_o)
  );

  // Subword MAC and the MULH steps
  short_mac u_short (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_i     (req),
    .step_i    (step),
    .ex_ready_i(ex_ready_i),
    .op_a_i    (op_a_i),
    .op_b_i    (op_b_i),
    .op_c_i    (op_c_i),
    .result_o  (short_result)
  );

  simd_mac u_simd (
    .req_i   (req),
    .op_a_i  (op_a_i),
    .op_b_i  (op_b_i),
    .op_c_i  (op_c_i),
    .result_o(simd_result)
  );

endmodule

// File: design/short_mac.sv
// 16x16 subword multiply-accumulate with rounding and shift, also runs the MULH partial steps
`timescale 1ns/1ps

module short_mac (
  input  logic                      clk,
  input  logic                      rst_n,
  input  mult_pkg::mult_req_t       req_i,
  input  mult_pkg::mult_step_t      step_i,
  input  logic                      ex_ready_i,
  input  logic [mult_pkg::XLEN-1:0] op_a_i,
  input  logic [mult_pkg::XLEN-1:0] op_b_i,
  input  logic [mult_pkg::XLEN-1:0] op_c_i,
  output logic [mult_pkg::XLEN-1:0] result_o
);

  mult_pkg::mult_word_u             a_w;
  mult_pkg::mult_word_u             b_w;
  logic [mult_pkg::IMM_W-1:0]       imm_sel;
  logic [1:0]                       subword_sel;
  logic [1:0]                       signed_sel;
  logic                             shift_arith;
  logic [mult_pkg::HALF_W-1:0]      a_half;
  logic [mult_pkg::HALF_W-1:0]      b_half;
  logic signed [mult_pkg::HALF_W:0] a_ext;
  logic signed [mult_pkg::HALF_W:0] b_ext;
  logic signed [mult_pkg::XLEN+1:0] product;
  logic signed [mult_pkg::XLEN+1:0] addend;
  logic [mult_pkg::XLEN+1:0]        round;
  logic signed [mult_pkg::XLEN+1:0] sum;
  logic signed [mult_pkg::XLEN+1:0] shifted;
  logic                             msb_hi;
  logic                             msb_lo;
  logic                             carry_q;
  logic [mult_pkg::XLEN-1:0]        partial_q;

  ////////////////////////////////////////////////////////////
  // Operand selection
  ////////////////////////////////////////////////////////////

  // Step controls take over while MULH runs
  assign imm_sel     = step_i.active ? step_i.imm         : req_i.imm;
  assign subword_sel = step_i.active ? step_i.subword     : {2{req_i.short_subword}};
  assign signed_sel  = step_i.active ? step_i.signed_ab   : req_i.short_signed;
  assign shift_arith = step_i.active ? step_i.shift_arith : req_i.short_signed[0];

  assign a_w    = op_a_i;
  assign b_w    = op_b_i;
  assign a_half = a_w.halves[subword_sel[0]];
  assign b_half = b_w.halves[subword_sel[1]];

  // 17-bit operands, sign bit only when that side is signed
  assign a_ext  = {signed_sel[0] & a_half[mult_pkg::HALF_W-1], a_half};
  assign b_ext  = {signed_sel[1] & b_half[mult_pkg::HALF_W-1], b_half};

  ////////////////////////////////////////////////////////////
  // Multiply, accumulate, round, shift
  ////////////////////////////////////////////////////////////

  assign product = a_ext * b_ext;
  // During MULH the running partial sum and its carry replace op_c
  assign addend  = step_i.active ? $signed({carry_q, partial_q}) : $signed(op_c_i);
  // Half an LSB of the shifted result, zero for imm of 0
  assign round   = (req_i.op == mult_pkg::MUL_IR) ? ((34'd1 << req_i.imm) >> 1) : '0;
  assign sum     = addend + product + $signed(round);

  // MULH keeps the two top sum bits, plain ops extend from bit 31
  assign msb_hi  = step_i.active ? sum[mult_pkg::XLEN+1] : sum[mult_pkg::XLEN-1];
  assign msb_lo  = step_i.active ? sum[mult_pkg::XLEN]   : sum[mult_pkg::XLEN-1];
  assign shifted = $signed({shift_arith & msb_hi, shift_arith & msb_lo,
                            sum[mult_pkg::XLEN-1:0]}) >>> imm_sel;

  assign result_o = shifted[mult_pkg::XLEN-1:0];

  // Carry of the 33-bit partial sum, dropped once the op retires
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      carry_q <= 1'b0;
    end else if (step_i.save_carry) begin
      carry_q <= ~step_i.clear_carry & sum[mult_pkg::XLEN];
    end else if (ex_ready_i) begin
      carry_q <= 1'b0;
    end
  end

  // Partial sum, zero on entry to STEP0 and frozen in FINISH
  always_ff @(posedge clk) begin
    if (step_i.save_carry) begin
      partial_q <= result_o;
    end else if (!step_i.active) begin
      partial_q <= '0;
    end
  end

endmodule

// File: design/simd_mac.sv
// 32-bit MAC and byte and halfword dot products with accumulate, selected by operator
`timescale 1ns/1ps

module simd_mac (
  input  mult_pkg::mult_req_t       req_i,
  input  logic [mult_pkg::XLEN-1:0] op_a_i,
  input  logic [mult_pkg::XLEN-1:0] op_b_i,
  input  logic [mult_pkg::XLEN-1:0] op_c_i,
  output logic [mult_pkg::XLEN-1:0] result_o
);

  mult_pkg::mult_word_u             a_w;
  mult_pkg::mult_word_u             b_w;
  // Lane products, kept at full word width
  logic signed [mult_pkg::XLEN-1:0] byte_mul [mult_pkg::NUM_BYTES];
  logic signed [mult_pkg::XLEN-1:0] half_mul [mult_pkg::NUM_HALVES];
  logic [mult_pkg::XLEN-1:0]        mac_result;
  logic [mult_pkg::XLEN-1:0]        dot8_result;
  logic [mult_pkg::XLEN-1:0]        dot16_result;

  assign a_w = op_a_i;
  assign b_w = op_b_i;

  ////////////////////////////////////////////////////////////
  // Full-word MAC
  ////////////////////////////////////////////////////////////

  // Low word only, so signedness does not matter
  assign mac_result = op_c_i + op_a_i * op_b_i;

  ////////////////////////////////////////////////////////////
  // Dot-product lanes
  ////////////////////////////////////////////////////////////

  // dot_signed bit 1 marks A lanes signed, bit 0 B lanes
  always_comb begin
    dot8_result = op_c_i;
    for (int i = 0; i < mult_pkg::NUM_BYTES; i++) begin
      byte_mul[i] =
        $signed({req_i.dot_signed[1] & a_w.bytes[i][mult_pkg::BYTE_W-1], a_w.bytes[i]}) *
        $signed({req_i.dot_signed[0] & b_w.bytes[i][mult_pkg::BYTE_W-1], b_w.bytes[i]});
      dot8_result = dot8_result + byte_mul[i];
    end
  end

  // Each halfword product truncated to the word before the sum
  always_comb begin
    dot16_result = op_c_i;
    for (int i = 0; i < mult_pkg::NUM_HALVES; i++) begin
      half_mul[i] =
        $signed({req_i.dot_signed[1] & a_w.halves[i][mult_pkg::HALF_W-1], a_w.halves[i]}) *
        $signed({req_i.dot_signed[0] & b_w.halves[i][mult_pkg::HALF_W-1], b_w.halves[i]});
      dot16_result = dot16_result + half_mul[i];
    end
  end

  // Unused codes fall back to the MAC
  always_comb begin
    case (req_i.op)
      mult_pkg::MUL_DOT8:  result_o = dot8_result;
      mult_pkg::MUL_DOT16: result_o = dot16_result;
      default:             result_o = mac_result;
    endcase
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the multiply unit testbench with Verilator and runs it.
# The exit status is 0 only when the run completes and its log holds no failure.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_mult \
  -f build.f --Mdir obj_dir -o tb_mult_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build did not complete"
  exit 1
fi

./obj_dir/tb_mult_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Testbench failed" "$SIM_LOG"; then
  echo "Result: FAIL"
  exit 1
fi
echo "Result: PASS"
exit 0

// File: tb/mult_props.sv
// Concurrent checks of the MULH sequencing, bound into every mult_ctrl instance
`timescale 1ns/1ps

module mult_props (
  input logic                      clk,
  input logic                      rst_n,
  input logic                      enable_i,
  input mult_pkg::mult_req_t       req_i,
  input logic                      ex_ready_i,
  input mult_pkg::mult_step_t      step_i,
  input logic [mult_pkg::XLEN-1:0] result_i,
  input logic                      ready_i,
  input logic                      multicycle_i
);

  logic in_finish;
  logic mulh_accept;

  // Only FINISH is both ready and under step control
  assign in_finish   = ready_i && step_i.active;
  // IDLE is the only state without step control
  assign mulh_accept = enable_i && !step_i.active && (req_i.op == mult_pkg::MUL_H);

  ////////////////////////////////////////////////////////////
  // Level outputs
  ////////////////////////////////////////////////////////////

  ready_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> ready_i && !multicycle_i)
    else $error("ready_o low or multicycle_o high right after reset");

  multicycle_not_ready: assert property (@(posedge clk) disable iff (!rst_n)
    multicycle_i |-> !ready_i)
    else $error("multicycle_o and ready_o high together");

  ////////////////////////////////////////////////////////////
  // MULH timing and back-pressure
  ////////////////////////////////////////////////////////////

  // Result must not move while the execute stage stalls
  finish_holds: assert property (@(posedge clk) disable iff (!rst_n)
    in_finish && !ex_ready_i |=> in_finish && $stable(result_i))
    else $error("FINISH left or result moved while ex_ready_i was low");

  // STEP2 precedes FINISH, so FINISH cannot show up early
  finish_after_four: assert property (@(posedge clk) disable iff (!rst_n)
    $past(mulh_accept, 4) |-> in_finish && !$past(in_finish))
    else $error("FINISH not reached exactly four cycles after MUL_H was accepted");

endmodule

bind mult_ctrl mult_props u_props (
  .clk         (clk),
  .rst_n       (rst_n),
  .enable_i    (enable_i),
  .req_i       (req_i),
  .ex_ready_i  (ex_ready_i),
  .step_i      (step_o),
  .result_i    (result_o),
  .ready_i     (ready_o),
  .multicycle_i(multicycle_o)
);

// File: tb/tb_mult.sv
// Random-stimulus testbench of the multiply unit, run as simulation top with the RTL of build.f
`timescale 1ns/1ps

module tb_mult;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 8;
  localparam int NUM_OPS      = 400;
  // Budget per op, a stalled MULH needs under ten
  localparam int OP_CYCLES    = 20;

  logic                       clk;
  logic                       rst_n;
  logic                       enable_i;
  mult_pkg::mult_op_e         operator_i;
  logic                       short_subword_i;
  logic [1:0]                 short_signed_i;
  logic [mult_pkg::IMM_W-1:0] imm_i;
  logic [1:0]                 dot_signed_i;
  logic [31:0]                op_a_i;
  logic [31:0]                op_b_i;
  logic [31:0]                op_c_i;
  logic                       ex_ready_i;
  logic [31:0]                result_o;
  logic                       ready_o;
  logic                       multicycle_o;
  logic [31:0]                rng;
  int                         errors;
  int                         checks;

  mult_unit uut (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Random source and reference model
  ////////////////////////////////////////////////////////////

  // 32-bit xorshift, shifts 13, 17, 5
  function automatic logic [31:0] xorshift_next();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // Widen the low w bits of v to 64, sign-filled when sgn is set
  function automatic logic [63:0] extend(input logic [31:0] v, input int w, input logic sgn);
    logic [63:0] mask;
    logic [63:0] r;
    mask = (64'd1 << w) - 64'd1;
    r    = {32'd0, v} & mask;
    if (sgn && v[w-1]) begin
      r = r | ~mask;
    end
    return r;
  endfunction

  function automatic logic [31:0] expected_result(input mult_pkg::mult_op_e op,
                                                  input logic [31:0] a, input logic [31:0] b,
                                                  input logic [31:0] c, input logic sub,
                                                  input logic [1:0] ss, input logic [4:0] imm,
                                                  input logic [1:0] ds);
    logic [63:0] acc;
    logic [63:0] rnd;
    logic [31:0] sum32;
    acc = {32'd0, c};
    case (op)
      mult_pkg::MUL_I, mult_pkg::MUL_IR: begin
        // Half an LSB of the shifted result, only for the rounding form
        rnd   = (op == mult_pkg::MUL_IR && imm != 0) ? (64'd1 << (imm - 1)) : 64'd0;
        acc   = acc + rnd + extend(sub ? a[31:16] : a[15:0], 16, ss[0]) *
                            extend(sub ? b[31:16] : b[15:0], 16, ss[1]);
        sum32 = acc[31:0];
        if (ss[0]) begin
          sum32 = $signed(sum32) >>> imm;
        end else begin
          sum32 = sum32 >> imm;
        end
        return sum32;
      end
      mult_pkg::MUL_H: begin
        // Upper word of the full 64-bit product
        acc = extend(a, 32, ss[0]) * extend(b, 32, ss[1]);
        return acc[63:32];
      end
      mult_pkg::MUL_DOT8: begin
        for (int i = 0; i < 4; i++) begin
          acc = acc + extend(a[8*i +: 8], 8, ds[1]) * extend(b[8*i +: 8], 8, ds[0]);
        end
      end
      mult_pkg::MUL_DOT16: begin
        for (int i = 0; i < 2; i++) begin
          acc = acc + extend(a[16*i +: 16], 16, ds[1]) * extend(b[16*i +: 16], 16, ds[0]);
        end
      end
      default: begin
        acc = acc + {32'd0, a} * {32'd0, b};
      end
    endcase
    return acc[31:0];
  endfunction

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("Error at t=%0t: %s", $time, what);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // One random operation
  ////////////////////////////////////////////////////////////

  task automatic run_op();
    mult_pkg::mult_op_e op;
    logic [31:0]        a;
    logic [31:0]        b;
    logic [31:0]        c;
    logic [31:0]        r;
    logic [31:0]        exp;
    int                 stall;
    logic               seen_multi;
    r = xorshift_next();
    case (r % 6)
      0: op = mult_pkg::MUL_MAC32;
      1: op = mult_pkg::MUL_I;
      2: op = mult_pkg::MUL_IR;
      3: op = mult_pkg::MUL_H;
      4: op = mult_pkg::MUL_DOT8;
      default: op = mult_pkg::MUL_DOT16;
    endcase
    a = xorshift_next();
    b = xorshift_next();
    c = xorshift_next();
    r = xorshift_next();
    // Unsigned A with signed B is no valid short signedness
    if (r[2:1] == 2'b10) begin
      r[2:1] = 2'b11;
    end
    exp   = expected_result(op, a, b, c, r[0], r[2:1], r[7:3], r[9:8]);
    stall = (op == mult_pkg::MUL_H) ? int'(r[11:10]) : 0;
    @(posedge clk);
    enable_i        <= 1'b1;
    operator_i      <= op;
    short_subword_i <= r[0];
    short_signed_i  <= r[2:1];
    imm_i           <= r[7:3];
    dot_signed_i    <= r[9:8];
    op_a_i          <= a;
    op_b_i          <= b;
    op_c_i          <= c;
    // Single-cycle ops ignore back-pressure, MULH stalls FINISH when stall is set
    ex_ready_i      <= (op == mult_pkg::MUL_H) ? (stall == 0) : r[12];
    @(negedge clk);
    if (op != mult_pkg::MUL_H) begin
      check_value("ready_o", ready_o, 32'd1);
      check_value("multicycle_o", multicycle_o, 32'd0);
      check_value("result_o", result_o, exp);
    end else begin
      check_value("ready_o", ready_o, 32'd0);
      seen_multi = 1'b0;
      do begin
        @(posedge clk);
        @(negedge clk);
        seen_multi = seen_multi | multicycle_o;
      end while (!ready_o);
      check_true(seen_multi, "MUL_H result came without multicycle_o going high");
      check_value("result_o", result_o, exp);
      // Held in FINISH, released on the last stall cycle
      for (int k = 0; k < stall; k++) begin
        @(posedge clk);
        if (k == stall - 1) begin
          ex_ready_i <= 1'b1;
        end
        @(negedge clk);
        check_value("ready_o", ready_o, 32'd1);
        check_value("result_o", result_o, exp);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    clk             = 1'b0;
    rst_n           = 1'b0;
    enable_i        = 1'b0;
    operator_i      = mult_pkg::MUL_MAC32;
    short_subword_i = 1'b0;
    short_signed_i  = 2'b00;
    imm_i           = '0;
    dot_signed_i    = 2'b00;
    op_a_i          = '0;
    op_b_i          = '0;
    op_c_i          = '0;
    ex_ready_i      = 1'b1;
    rng             = 32'h3d06;
    errors          = 0;
    checks          = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("ready_o", ready_o, 32'd1);
    check_value("multicycle_o", multicycle_o, 32'd0);
    for (int n = 0; n < NUM_OPS; n++) begin
      run_op();
    end
    @(posedge clk);
    enable_i <= 1'b0;
    @(negedge clk);
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    #((NUM_OPS * OP_CYCLES + RESET_CYCLES) * CLK_PERIOD);
    $display("Watchdog expired, run did not finish after %0d ops worth of cycles", NUM_OPS);
    $display("Summary: %0d checks, %0d errors", checks, errors);
    $display("Testbench failed");
    $finish;
  end

endmodule
